// File: source/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// ==========================================================================
// Bus and datapath widths
// ==========================================================================

// Bus width and micro-op width are the same, one op per write
`define DECODE_DATA_WIDTH 32
`define DECODE_ADDR_WIDTH 8
`define DECODE_STRB_WIDTH (`DECODE_DATA_WIDTH / 8)

// Statistics counters wrap silently at this width
`define DECODE_STAT_WIDTH 16
// One counter for each real functional unit: ALU, MUL, BRANCH, MEM
`define DECODE_COUNT_NUM 4

// ==========================================================================
// Register map
// ==========================================================================

`define DECODE_REG_OPWORD 8'h00
`define DECODE_REG_RESULT 8'h04
`define DECODE_REG_CTRL 8'h08
// Counters sit at 0x10, 0x14, 0x18 and 0x1C
`define DECODE_REG_COUNT_BASE 8'h10

`endif

// File: source/decodePkg.sv
`include "decode_settings.svh"

package decodePkg;

	// ======================================================================
	// Enumerations
	// ======================================================================

	// Six bit major opcode, codes not listed here are undefined
	typedef enum logic [5:0] {
		OP_NOP = 6'h00,
		OP_ADD = 6'h01,
		OP_SUB = 6'h02,
		OP_AND = 6'h03,
		OP_MUL = 6'h04,
		OP_BEQ = 6'h05,
		OP_BNE = 6'h06,
		OP_JMP = 6'h07,
		// Loads
		OP_LDB = 6'h10,
		OP_LDW = 6'h11,
		OP_LDT = 6'h12,
		OP_LDO = 6'h13,
		OP_LDV = 6'h14,
		// Stores, STVX is the indexed vector store
		OP_STB = 6'h18,
		OP_STW = 6'h19,
		OP_STT = 6'h1A,
		OP_STORE = 6'h1B,
		OP_STI = 6'h1C,
		OP_STPTR = 6'h1D,
		OP_STV = 6'h1E,
		OP_STVX = 6'h1F
	} opcodeE;

	// Counter slots follow the order ALU, MUL, BRANCH, MEM
	typedef enum logic [2:0] {
		UNIT_NONE = 3'd0,
		UNIT_ALU = 3'd1,
		UNIT_MUL = 3'd2,
		UNIT_BRANCH = 3'd3,
		UNIT_MEM = 3'd4
	} unitE;

	// Byte, wyde (16), tetra (32) and octa (64) accesses
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_WYDE = 2'd1,
		SIZE_TETRA = 2'd2,
		SIZE_OCTA = 2'd3
	} sizeE;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axiRespE;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_WRESP,
		ST_RRESP
	} ctrlStateE;

	// ======================================================================
	// Structures
	// ======================================================================

	// Opcode in the top six bits, immediate in the low byte
	typedef struct packed {
		opcodeE opcode;
		logic [5:0] rd;
		logic [5:0] ra;
		logic [5:0] rb;
		logic [7:0] imm;
	} microOpT;

	// Result word, store sits in the most significant bit
	typedef struct packed {
		logic store;
		logic vstore;
		logic vstoreNdx;
		logic load;
		logic vload;
		unitE unit;
		sizeE memSize;
		logic illegal;
	} decodeFlagsT;

	typedef struct packed {
		logic awvalid;
		logic [`DECODE_ADDR_WIDTH-1:0] awaddr;
		logic wvalid;
		logic [`DECODE_DATA_WIDTH-1:0] wdata;
		logic [`DECODE_STRB_WIDTH-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [`DECODE_ADDR_WIDTH-1:0] araddr;
		logic rready;
	} axiLiteReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axiRespE bresp;
		logic arready;
		logic rvalid;
		logic [`DECODE_DATA_WIDTH-1:0] rdata;
		axiRespE rresp;
	} axiLiteRespT;

endpackage

// File: source/decodeStore.sv
`timescale 1ns/10ps

module decodeStore
(
	input decodePkg::microOpT opWord,
	output logic store,
	output logic vstore,
	output logic vstoreNdx
);
	import decodePkg::*;

	// Scalar stores of every width, including the immediate and pointer forms
	function automatic logic fnIsStore(input microOpT op);
		case (op.opcode)
		OP_STB, OP_STW, OP_STT, OP_STORE, OP_STI, OP_STPTR:
			fnIsStore = 1'b1;
		default:
			fnIsStore = 1'b0;
		endcase
	endfunction

	// Both vector store forms count as a vector store
	function automatic logic fnIsStoreVec(input microOpT op);
		case (op.opcode)
		OP_STV, OP_STVX:
			fnIsStoreVec = 1'b1;
		default:
			fnIsStoreVec = 1'b0;
		endcase
	endfunction

	// Only the indexed form takes its addresses from a vector register
	function automatic logic fnIsStoreNdx(input microOpT op);
		fnIsStoreNdx = op.opcode == OP_STVX;
	endfunction

	assign store = fnIsStore(opWord);
	assign vstore = fnIsStoreVec(opWord);
	assign vstoreNdx = fnIsStoreNdx(opWord);

endmodule

// File: source/decodeLoad.sv
`timescale 1ns/10ps

module decodeLoad
(
	input decodePkg::microOpT opWord,
	output logic load,
	output logic vload
);
	import decodePkg::*;

	// ======================================================================
	// Opcode classifiers
	// ======================================================================

	// Scalar loads from byte up to octa width
	function automatic logic fnIsLoad(input microOpT op);
		case (op.opcode)
		OP_LDB, OP_LDW, OP_LDT, OP_LDO:
			fnIsLoad = 1'b1;
		default:
			fnIsLoad = 1'b0;
		endcase
	endfunction

	// There is a single vector load, it has no indexed form
	function automatic logic fnIsLoadVec(input microOpT op);
		case (op.opcode)
		OP_LDV:
			fnIsLoadVec = 1'b1;
		default:
			fnIsLoadVec = 1'b0;
		endcase
	endfunction

	// ======================================================================
	// Outputs
	// ======================================================================

	// A vector load never raises the scalar load flag
	assign load = fnIsLoad(opWord);
	assign vload = fnIsLoadVec(opWord);

endmodule

// File: source/decodeUnit.sv
`timescale 1ns/10ps

module decodeUnit
(
	input decodePkg::microOpT opWord,
	output decodePkg::unitE unit,
	output decodePkg::sizeE memSize,
	output logic illegal
);
	import decodePkg::*;

	always_comb
	begin
		// Non-memory ops report byte size, undefined codes fall to the default
		unit = UNIT_NONE;
		memSize = SIZE_BYTE;
		illegal = 1'b0;
		case (opWord.opcode)
		OP_NOP, OP_ADD, OP_SUB, OP_AND:
			unit = UNIT_ALU;
		OP_MUL:
			unit = UNIT_MUL;
		OP_BEQ, OP_BNE, OP_JMP:
			unit = UNIT_BRANCH;
		OP_LDB, OP_STB:
			unit = UNIT_MEM;
		OP_LDW, OP_STW:
		begin
			unit = UNIT_MEM;
			memSize = SIZE_WYDE;
		end
		OP_LDT, OP_STT, OP_STI:
		begin
			unit = UNIT_MEM;
			memSize = SIZE_TETRA;
		end
		// Pointers and vector elements are always full octa width
		OP_LDO, OP_STORE, OP_STPTR, OP_LDV, OP_STV, OP_STVX:
		begin
			unit = UNIT_MEM;
			memSize = SIZE_OCTA;
		end
		default:
			illegal = 1'b1;
		endcase
	end

endmodule

// File: source/decodeStats.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decodeStats
(
	input logic clk,
	input logic rstN,
	input logic countEn,
	input logic countClear,
	input decodePkg::unitE unit,
	output logic [`DECODE_COUNT_NUM-1:0][`DECODE_STAT_WIDTH-1:0] counts
);
	import decodePkg::*;

	logic [$clog2(`DECODE_COUNT_NUM)-1:0] slot;
	logic slotValid;

	// Map the unit onto a counter slot, UNIT_NONE has no counter
	always_comb
	begin
		slot = '0;
		slotValid = 1'b1;
		case (unit)
		UNIT_ALU:
			slot = 2'd0;
		UNIT_MUL:
			slot = 2'd1;
		UNIT_BRANCH:
			slot = 2'd2;
		UNIT_MEM:
			slot = 2'd3;
		default:
			slotValid = 1'b0;
		endcase
	end

	// ======================================================================
	// Counter bank
	// ======================================================================

	// A clear in the same cycle as a count drops the count
	always_ff @(posedge clk)
	begin
		if (!rstN)
			counts <= '0;
		else if (countClear)
			counts <= '0;
		else if (countEn && slotValid)
			// Wraps back to zero past the top of the counter
			counts[slot] <= counts[slot] + 1'b1;
	end

endmodule

// File: source/decodeCtrl.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decodeCtrl
(
	input logic clk,
	input logic rstN,
	input decodePkg::axiLiteReqT axiReq,
	output decodePkg::axiLiteRespT axiResp,
	output decodePkg::microOpT opWord,
	input decodePkg::decodeFlagsT flags,
	input logic [`DECODE_COUNT_NUM-1:0][`DECODE_STAT_WIDTH-1:0] counts,
	output logic countEn,
	output logic countClear
);
	import decodePkg::*;

	localparam logic [`DECODE_ADDR_WIDTH-1:0] countBase = `DECODE_REG_COUNT_BASE;

	ctrlStateE state;
	decodeFlagsT result;
	axiRespE bresp;
	axiRespE rresp;
	logic [`DECODE_DATA_WIDTH-1:0] rdata;
	logic [`DECODE_DATA_WIDTH-1:0] muxData;
	axiRespE muxResp;
	logic wrHs;
	logic rdHs;
	logic opWordHit;
	logic ctrlHit;

	// Write needs address and data together and wins over a read
	assign wrHs = state == ST_IDLE && axiReq.awvalid && axiReq.wvalid;
	assign rdHs = state == ST_IDLE && axiReq.arvalid && !wrHs;
	// A partial op word would be meaningless, so all strobes are required
	assign opWordHit = axiReq.awaddr == `DECODE_REG_OPWORD && &axiReq.wstrb;
	assign ctrlHit = axiReq.awaddr == `DECODE_REG_CTRL;
	// Counters sample the unit while the FSM sits in the decode state
	assign countEn = state == ST_DECODE;

	// ======================================================================
	// Read mux
	// ======================================================================

	always_comb
	begin
		// Write-only and unmapped addresses read as zero with an error
		muxData = '0;
		muxResp = RESP_SLVERR;
		if (axiReq.araddr == `DECODE_REG_RESULT)
		begin
			muxData[$bits(decodeFlagsT)-1:0] = result;
			muxResp = RESP_OKAY;
		end
		else if (axiReq.araddr[`DECODE_ADDR_WIDTH-1:4] == countBase[`DECODE_ADDR_WIDTH-1:4]
			&& axiReq.araddr[1:0] == 2'b00)
		begin
			muxData[`DECODE_STAT_WIDTH-1:0] = counts[axiReq.araddr[3:2]];
			muxResp = RESP_OKAY;
		end
	end

	// ======================================================================
	// Control FSM
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= ST_IDLE;
			result <= '0;
			bresp <= RESP_OKAY;
			rresp <= RESP_OKAY;
			countClear <= 1'b0;
		end
		else
		begin
			countClear <= 1'b0;
			case (state)
			ST_IDLE:
				if (wrHs)
				begin
					// Bad writes go straight to the response and touch nothing
					bresp <= (opWordHit || ctrlHit) ? RESP_OKAY : RESP_SLVERR;
					countClear <= ctrlHit && axiReq.wstrb[0] && axiReq.wdata[0];
					state <= opWordHit ? ST_DECODE : ST_WRESP;
				end
				else if (rdHs)
				begin
					rresp <= muxResp;
					state <= ST_RRESP;
				end
			ST_DECODE:
			begin
				result <= flags;
				state <= ST_WRESP;
			end
			// Response stays up until the master takes it
			ST_WRESP:
				if (axiReq.bready)
					state <= ST_IDLE;
			ST_RRESP:
				if (axiReq.rready)
					state <= ST_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// Op word and read data are plain payload latched on the handshake
	always_ff @(posedge clk)
	begin
		if (wrHs && opWordHit)
			opWord <= microOpT'(axiReq.wdata);
		if (rdHs)
			rdata <= muxData;
	end

	always_comb
	begin
		axiResp.awready = wrHs;
		axiResp.wready = wrHs;
		axiResp.bvalid = state == ST_WRESP;
		axiResp.bresp = bresp;
		axiResp.arready = rdHs;
		axiResp.rvalid = state == ST_RRESP;
		axiResp.rdata = rdata;
		axiResp.rresp = rresp;
	end

endmodule

// File: source/decodeTop.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decodeTop
(
	input logic clk,
	input logic rstN,
	input decodePkg::axiLiteReqT axiReq,
	output decodePkg::axiLiteRespT axiResp
);
	import decodePkg::*;

	microOpT opWord;
	decodeFlagsT flags;
	logic isStore;
	logic isVstore;
	logic isVstoreNdx;
	logic isLoad;
	logic isVload;
	unitE unit;
	sizeE memSize;
	logic illegal;
	logic countEn;
	logic countClear;
	logic [`DECODE_COUNT_NUM-1:0][`DECODE_STAT_WIDTH-1:0] counts;

	// ======================================================================
	// Bus slave and result register
	// ======================================================================

	decodeCtrl decodeCtrl_i (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiResp(axiResp),
		.opWord(opWord),
		.flags(flags),
		.counts(counts),
		.countEn(countEn),
		.countClear(countClear)
	);

	// ======================================================================
	// Combinational classifiers
	// ======================================================================

	decodeStore decodeStore_i (
		.opWord(opWord),
		.store(isStore),
		.vstore(isVstore),
		.vstoreNdx(isVstoreNdx)
	);

	decodeLoad decodeLoad_i (
		.opWord(opWord),
		.load(isLoad),
		.vload(isVload)
	);

	decodeUnit decodeUnit_i (
		.opWord(opWord),
		.unit(unit),
		.memSize(memSize),
		.illegal(illegal)
	);

	// Gather the classifier outputs into the result word layout
	assign flags = '{
		store: isStore,
		vstore: isVstore,
		vstoreNdx: isVstoreNdx,
		load: isLoad,
		vload: isVload,
		unit: unit,
		memSize: memSize,
		illegal: illegal
	};

	// Counts per unit, the unit comes straight from the unit decoder
	decodeStats decodeStats_i (
		.clk(clk),
		.rstN(rstN),
		.countEn(countEn),
		.countClear(countClear),
		.unit(unit),
		.counts(counts)
	);

endmodule

// File: test/decodeTbTasks.svh
`ifndef DECODE_TB_TASKS_SVH
`define DECODE_TB_TASKS_SVH

// ==========================================================================
// Failure reporting and typed compares
// ==========================================================================

// Print what went wrong, then the fail banner, and stop the run
task automatic abortRun(input string reason);
	$display("%s", reason);
	$display("=== FAIL ===");
	$fatal(1, "Simulation stopped at the first error");
endtask

task automatic checkFlags(input string name, input decodeFlagsT expected,
	input decodeFlagsT actual);
	if (actual !== expected)
		abortRun($sformatf("[FAIL] %s: expected flags %03h, actual %03h",
			name, expected, actual));
endtask

task automatic checkResp(input string name, input axiRespE expected, input axiRespE actual);
	if (actual !== expected)
		abortRun($sformatf("[FAIL] %s: expected response %02b, actual %02b",
			name, expected, actual));
endtask

task automatic checkCount(input string name, input logic [`DECODE_STAT_WIDTH-1:0] expected,
	input logic [`DECODE_STAT_WIDTH-1:0] actual);
	if (actual !== expected)
		abortRun($sformatf("[FAIL] %s: expected count %0d, actual %0d",
			name, expected, actual));
endtask

// Compares the whole read word and so also catches bits above the flags or a counter
task automatic checkData(input string name, input logic [`DECODE_DATA_WIDTH-1:0] expected,
	input logic [`DECODE_DATA_WIDTH-1:0] actual);
	if (actual !== expected)
		abortRun($sformatf("[FAIL] %s: expected data %08h, actual %08h",
			name, expected, actual));
endtask

// ==========================================================================
// AXI4-Lite master
// ==========================================================================

// One clock of a bounded wait
// Outputs are looked at just after the rising edge, so they still hold the pre-edge value
task automatic tickWithLimit(inout int waitCount, input string what);
	@(posedge clk);
	waitCount++;
	if (waitCount > waitLimit)
		abortRun($sformatf("Timed out after %0d cycles waiting for %s", waitLimit, what));
endtask

task automatic axiWrite(input string name, input logic [`DECODE_ADDR_WIDTH-1:0] addr,
	input logic [`DECODE_DATA_WIDTH-1:0] data, input logic [`DECODE_STRB_WIDTH-1:0] strb,
	output axiRespE resp);
	int waitCount;
	int holdCycles;
	@(negedge clk);
	axiReq.awvalid = 1'b1;
	axiReq.awaddr = addr;
	axiReq.wvalid = 1'b1;
	axiReq.wdata = data;
	axiReq.wstrb = strb;
	// Address and data are offered together and taken on the same edge
	waitCount = 0;
	do
		tickWithLimit(waitCount, {name, ": write address and data handshake"});
	while (!(axiResp.awready === 1'b1 && axiResp.wready === 1'b1));
	@(negedge clk);
	axiReq.awvalid = 1'b0;
	axiReq.wvalid = 1'b0;
	waitCount = 0;
	do
		tickWithLimit(waitCount, {name, ": bvalid"});
	while (axiResp.bvalid !== 1'b1);
	resp = axiResp.bresp;
	// Withhold bready for a few cycles while the response has to sit still
	holdCycles = $urandom % 4;
	repeat (holdCycles)
	begin
		@(posedge clk);
		if (axiResp.bvalid !== 1'b1 || axiResp.bresp !== resp)
			abortRun($sformatf("%s: write response moved while bready was low", name));
	end
	@(negedge clk);
	axiReq.bready = 1'b1;
	@(negedge clk);
	axiReq.bready = 1'b0;
endtask

task automatic axiRead(input string name, input logic [`DECODE_ADDR_WIDTH-1:0] addr,
	output logic [`DECODE_DATA_WIDTH-1:0] data, output axiRespE resp);
	int waitCount;
	int holdCycles;
	@(negedge clk);
	axiReq.arvalid = 1'b1;
	axiReq.araddr = addr;
	waitCount = 0;
	do
		tickWithLimit(waitCount, {name, ": read address handshake"});
	while (axiResp.arready !== 1'b1);
	@(negedge clk);
	axiReq.arvalid = 1'b0;
	waitCount = 0;
	do
		tickWithLimit(waitCount, {name, ": rvalid"});
	while (axiResp.rvalid !== 1'b1);
	data = axiResp.rdata;
	resp = axiResp.rresp;
	// Data and response both stay frozen until rready comes
	holdCycles = $urandom % 4;
	repeat (holdCycles)
	begin
		@(posedge clk);
		if (axiResp.rvalid !== 1'b1 || axiResp.rdata !== data || axiResp.rresp !== resp)
			abortRun($sformatf("%s: read response moved while rready was low", name));
	end
	@(negedge clk);
	axiReq.rready = 1'b1;
	@(negedge clk);
	axiReq.rready = 1'b0;
endtask

`endif

// File: test/decodeTb.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decodeTb;
	import decodePkg::*;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	localparam int waitLimit = 64;
	localparam int randSeed = 32'hbc5a;

	logic clk;
	logic rstN;
	axiLiteReqT axiReq;
	axiLiteRespT axiResp;
	int fd;
	int lineNo;
	int fields;
	int slot;
	string line;
	string kind;
	string respText;
	string note;
	string testName;
	logic [`DECODE_ADDR_WIDTH-1:0] addr;
	logic [`DECODE_DATA_WIDTH-1:0] wdata;
	logic [`DECODE_STRB_WIDTH-1:0] strb;
	logic [`DECODE_DATA_WIDTH-1:0] value;
	axiRespE expResp;
	axiRespE gotResp;
	decodeFlagsT expFlags;
	// Running count of decoded ops per unit, built from the stimulus file
	logic [`DECODE_STAT_WIDTH-1:0] tally [`DECODE_COUNT_NUM];

	`include "decodeTbTasks.svh"

	decodeTop decodeTop_i (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiResp(axiResp)
	);

	// Counter offsets follow the register map order ALU, MUL, BRANCH, MEM
	function automatic int unitSlot(input unitE unit);
		case (unit)
		UNIT_ALU:
			unitSlot = 0;
		UNIT_MUL:
			unitSlot = 1;
		UNIT_BRANCH:
			unitSlot = 2;
		UNIT_MEM:
			unitSlot = 3;
		default:
			unitSlot = -1;
		endcase
	endfunction

	// Read one register and check it against the file and, for counters, the tally
	task automatic readAndCheck(input string name, input logic [`DECODE_ADDR_WIDTH-1:0] rdAddr,
		input axiRespE wantResp, input logic [`DECODE_DATA_WIDTH-1:0] want);
		logic [`DECODE_DATA_WIDTH-1:0] gotData;
		axiRespE resp;
		int idx;
		axiRead(name, rdAddr, gotData, resp);
		checkResp(name, wantResp, resp);
		if (rdAddr == `DECODE_REG_RESULT)
			checkFlags(name, decodeFlagsT'(want[$bits(decodeFlagsT)-1:0]),
				decodeFlagsT'(gotData[$bits(decodeFlagsT)-1:0]));
		else if (wantResp == RESP_OKAY && rdAddr >= `DECODE_REG_COUNT_BASE)
		begin
			idx = (rdAddr - `DECODE_REG_COUNT_BASE) >> 2;
			if (idx < `DECODE_COUNT_NUM)
				checkCount(name, tally[idx], gotData[`DECODE_STAT_WIDTH-1:0]);
		end
		checkData(name, want, gotData);
	endtask

	// ======================================================================
	// Clock and stimulus
	// ======================================================================

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		rstN = 1'b0;
		axiReq = '0;
		foreach (tally[i])
			tally[i] = '0;
		void'($urandom(randSeed));
		// Neither response channel may show valid while reset is held
		repeat (resetCycles)
		begin
			@(negedge clk);
			if (axiResp.bvalid !== 1'b0 || axiResp.rvalid !== 1'b0)
				abortRun("A response valid signal was not low during reset");
		end
		rstN = 1'b1;
		fd = $fopen("test/decode_input.txt", "r");
		if (fd == 0)
			abortRun("The stimulus file test/decode_input.txt could not be opened");
		lineNo = 0;
		while ($fgets(line, fd) != 0)
		begin
			lineNo++;
			if (line.len() < 2 || line[0] == "#")
				continue;
			note = "";
			fields = $sscanf(line, "%s %h %h %h %s %h %s",
				kind, addr, wdata, strb, respText, value, note);
			if (fields < 6 || (kind != "W" && kind != "R"))
				abortRun($sformatf("Line %0d of the stimulus file is not a transaction", lineNo));
			testName = $sformatf("line %0d %s", lineNo, note);
			expResp = (respText == "SLVERR") ? RESP_SLVERR : RESP_OKAY;
			if (kind == "R")
				readAndCheck(testName, addr, expResp, value);
			else
			begin
				axiWrite(testName, addr, wdata, strb, gotResp);
				checkResp(testName, expResp, gotResp);
				if (addr == `DECODE_REG_OPWORD && expResp == RESP_OKAY)
				begin
					// The expected unit picks the counter that this op adds to
					expFlags = decodeFlagsT'(value[$bits(decodeFlagsT)-1:0]);
					slot = unitSlot(expFlags.unit);
					if (slot >= 0)
						tally[slot] = tally[slot] + 1'b1;
					readAndCheck({testName, " result"}, `DECODE_REG_RESULT, RESP_OKAY, value);
				end
				else if (addr == `DECODE_REG_CTRL && expResp == RESP_OKAY && strb[0] && wdata[0])
					foreach (tally[i])
						tally[i] = '0;
			end
		end
		$fclose(fd);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: test/decode_input.txt
# kind addr wdata strb resp value note, numbers in hex
# An OKAY op word write is followed by a RESULT read that must equal value
R 04 00000000 0 OKAY 00000000 resetResult
R 10 00000000 0 OKAY 00000000 resetAlu
R 14 00000000 0 OKAY 00000000 resetMul
R 18 00000000 0 OKAY 00000000 resetBranch
R 1C 00000000 0 OKAY 00000000 resetMem
W 00 601234AB F OKAY 00000420 STB
W 00 641234AB F OKAY 00000422 STW
W 00 681234AB F OKAY 00000424 STT
W 00 6C1234AB F OKAY 00000426 STORE
W 00 701234AB F OKAY 00000424 STI
W 00 741234AB F OKAY 00000426 STPTR
W 00 781234AB F OKAY 00000226 STV
W 00 7C1234AB F OKAY 00000326 STVX
W 00 401234AB F OKAY 000000A0 LDB
W 00 441234AB F OKAY 000000A2 LDW
W 00 481234AB F OKAY 000000A4 LDT
W 00 4C1234AB F OKAY 000000A6 LDO
W 00 501234AB F OKAY 00000066 LDV
W 00 04ABCDEF F OKAY 00000008 ADD
W 00 08ABCDEF F OKAY 00000008 SUB
W 00 10ABCDEF F OKAY 00000010 MUL
W 00 14ABCDEF F OKAY 00000018 BEQ
W 00 1CABCDEF F OKAY 00000018 JMP
W 00 20ABCDEF F OKAY 00000001 undefined08
W 00 FCABCDEF F OKAY 00000001 undefined3F
W 0C 00000001 F SLVERR 00000000 unmappedWrite
W 00 04ABCDEF 7 SLVERR 00000000 partialStrobe
R 00 00000000 0 SLVERR 00000000 readOpWord
R 20 00000000 0 SLVERR 00000000 unmappedRead
R 04 00000000 0 OKAY 00000001 resultKept
R 10 00000000 0 OKAY 00000002 countAlu
R 14 00000000 0 OKAY 00000001 countMul
R 18 00000000 0 OKAY 00000002 countBranch
R 1C 00000000 0 OKAY 0000000D countMem
W 08 00000001 1 OKAY 00000000 clearCounts
R 10 00000000 0 OKAY 00000000 clearedAlu
R 14 00000000 0 OKAY 00000000 clearedMul
R 18 00000000 0 OKAY 00000000 clearedBranch
R 1C 00000000 0 OKAY 00000000 clearedMem

// File: filelist.f
+incdir+source
+incdir+test
source/decodePkg.sv
source/decodeStore.sv
source/decodeLoad.sv
source/decodeUnit.sv
source/decodeStats.sv
source/decodeCtrl.sv
source/decodeTop.sv
test/decodeTb.sv
